/* include/rename_settings.svh */
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// architectural register file
`define N_REGS 32
`define REG_W  5

// one register word
`define DATA_W 32

// 8 producer tags in flight
`define TAG_W  3

`endif

/* rtl/rename_pkg.sv */
`include "rename_settings.svh"

package rename_pkg;

    // register value
    typedef logic [`DATA_W-1:0] data_t;

    // architectural register number
    typedef logic [`REG_W-1:0]  reg_addr_t;

    // producer tag from the pool
    typedef logic [`TAG_W-1:0]  tag_t;

endpackage

/* rtl/tagged_regfile.sv */
`include "rename_settings.svh"

module tagged_regfile (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  rename_pkg::reg_addr_t rd1_addr_i,
    input  rename_pkg::reg_addr_t rd2_addr_i,

    output rename_pkg::data_t     rd1_data_o,
    output logic                  rd1_ready_o,
    output rename_pkg::tag_t      rd1_tag_o,
    output rename_pkg::data_t     rd2_data_o,
    output logic                  rd2_ready_o,
    output rename_pkg::tag_t      rd2_tag_o,

    input  logic                  wb_i,
    input  rename_pkg::reg_addr_t wb_dst_i,
    input  rename_pkg::tag_t      wb_tag_i,
    input  rename_pkg::data_t     wb_data_i,

    input  logic                  bind_i,
    input  rename_pkg::reg_addr_t bind_dst_i,
    input  rename_pkg::tag_t      bind_tag_i
);
    import rename_pkg::*;

    data_t              val_q [`N_REGS];
    data_t              val_d [`N_REGS];
    tag_t               tag_q [`N_REGS];
    tag_t               tag_d [`N_REGS];
    logic [`N_REGS-1:0] ready_q;
    logic [`N_REGS-1:0] ready_d;

    always_comb begin
        val_d   = val_q;
        tag_d   = tag_q;
        ready_d = ready_q;

        if (wb_i) begin
            val_d[wb_dst_i] = wb_data_i;  // value lands even from a stale producer
            if (tag_q[wb_dst_i] == wb_tag_i) begin
                ready_d[wb_dst_i] = 1'b1;
            end
        end

        // a new producer overrides a same-cycle writeback
        if (bind_i) begin
            tag_d[bind_dst_i]   = bind_tag_i;
            ready_d[bind_dst_i] = 1'b0;
        end

        // r0 hardwired
        val_d[0]   = '0;
        tag_d[0]   = '0;
        ready_d[0] = 1'b1;
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `N_REGS; i++) begin
                val_q[i] <= '0;
                tag_q[i] <= '0;
            end
            ready_q <= '1;
        end else begin
            val_q   <= val_d;
            tag_q   <= tag_d;
            ready_q <= ready_d;
        end
    end

    // reads see the state before the edge
    assign rd1_data_o  = val_q[rd1_addr_i];
    assign rd1_ready_o = ready_q[rd1_addr_i];
    assign rd1_tag_o   = tag_q[rd1_addr_i];

    assign rd2_data_o  = val_q[rd2_addr_i];
    assign rd2_ready_o = ready_q[rd2_addr_i];
    assign rd2_tag_o   = tag_q[rd2_addr_i];  // own address for port 2

endmodule

/* rtl/tag_allocator.sv */
`include "rename_settings.svh"

module tag_allocator (
    input  logic             clk_i,
    input  logic             rstn_i,

    input  logic             take_i,
    input  logic             release_i,
    input  rename_pkg::tag_t release_tag_i,

    output rename_pkg::tag_t alloc_tag_o,
    output logic             free_any_o
);
    import rename_pkg::*;

    localparam int N_TAGS = 1 << `TAG_W;

    logic [N_TAGS-1:0] free_q;
    logic [N_TAGS-1:0] free_d;
    tag_t              lowest;

    // scan downward so the lowest free index wins
    always_comb begin
        lowest = '0;
        for (int i = N_TAGS - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                lowest = tag_t'(i);
            end
        end
    end

    // take and release never hit the same tag
    always_comb begin
        free_d = free_q;
        if (take_i) begin
            free_d[lowest] = 1'b0;
        end
        if (release_i) begin
            free_d[release_tag_i] = 1'b1;  // usable from next cycle
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            free_q <= '1;  // whole pool free
        end else begin
            free_q <= free_d;
        end
    end

    assign alloc_tag_o = lowest;
    assign free_any_o  = |free_q;

endmodule

/* rtl/operand_capture.sv */
module operand_capture (
    input  logic              clk_i,
    input  logic              rstn_i,

    input  logic              accept_i,
    input  rename_pkg::tag_t  tag_i,

    input  rename_pkg::data_t a_data_i,
    input  logic              a_ready_i,
    input  rename_pkg::tag_t  a_tag_i,
    input  rename_pkg::data_t b_data_i,
    input  logic              b_ready_i,
    input  rename_pkg::tag_t  b_tag_i,

    input  logic              wb_i,
    input  rename_pkg::tag_t  wb_tag_i,
    input  rename_pkg::data_t wb_data_i,

    output logic              issue_o,
    output rename_pkg::tag_t  issue_tag_o,
    output rename_pkg::data_t opa_data_o,
    output logic              opa_ready_o,
    output rename_pkg::tag_t  opa_tag_o,
    output rename_pkg::data_t opb_data_o,
    output logic              opb_ready_o,
    output rename_pkg::tag_t  opb_tag_o
);
    import rename_pkg::*;

    logic wake_a;
    logic wake_b;

    // producer finishing in the accept cycle
    assign wake_a = wb_i && !a_ready_i && (wb_tag_i == a_tag_i);
    assign wake_b = wb_i && !b_ready_i && (wb_tag_i == b_tag_i);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            issue_o <= 1'b0;
        end else begin
            issue_o <= accept_i;  // one-cycle pulse
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            issue_tag_o <= tag_i;

            opa_data_o  <= wake_a ? wb_data_i : a_data_i;
            opa_ready_o <= a_ready_i | wake_a;
            opa_tag_o   <= a_tag_i;

            opb_data_o  <= wake_b ? wb_data_i : b_data_i;
            opb_ready_o <= b_ready_i | wake_b;
            opb_tag_o   <= b_tag_i;
        end
    end

endmodule

/* rtl/rename_stage.sv */
module rename_stage (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  logic                  disp_i,
    input  rename_pkg::reg_addr_t disp_dst_i,
    input  rename_pkg::reg_addr_t disp_src1_i,
    input  rename_pkg::reg_addr_t disp_src2_i,
    output logic                  stall_o,

    input  logic                  wb_i,
    input  rename_pkg::reg_addr_t wb_dst_i,
    input  rename_pkg::tag_t      wb_tag_i,
    input  rename_pkg::data_t     wb_data_i,

    output logic                  issue_o,
    output rename_pkg::tag_t      issue_tag_o,
    output rename_pkg::data_t     opa_data_o,
    output logic                  opa_ready_o,
    output rename_pkg::tag_t      opa_tag_o,
    output rename_pkg::data_t     opb_data_o,
    output logic                  opb_ready_o,
    output rename_pkg::tag_t      opb_tag_o
);
    import rename_pkg::*;

    tag_t  alloc_tag;
    logic  free_any;
    logic  accept;

    data_t rd1_data;
    logic  rd1_ready;
    tag_t  rd1_tag;
    data_t rd2_data;
    logic  rd2_ready;
    tag_t  rd2_tag;

    // only stall source is an empty tag pool
    assign stall_o = ~free_any;
    assign accept  = disp_i & free_any;

    tag_allocator u_alloc (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .take_i       (accept),
        .release_i    (wb_i),
        .release_tag_i(wb_tag_i),
        .alloc_tag_o  (alloc_tag),
        .free_any_o   (free_any)
    );

    tagged_regfile u_rf (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rd1_addr_i (disp_src1_i),
        .rd2_addr_i (disp_src2_i),
        .rd1_data_o (rd1_data),
        .rd1_ready_o(rd1_ready),
        .rd1_tag_o  (rd1_tag),
        .rd2_data_o (rd2_data),
        .rd2_ready_o(rd2_ready),
        .rd2_tag_o  (rd2_tag),
        .wb_i       (wb_i),
        .wb_dst_i   (wb_dst_i),
        .wb_tag_i   (wb_tag_i),
        .wb_data_i  (wb_data_i),
        .bind_i     (accept),
        .bind_dst_i (disp_dst_i),
        .bind_tag_i (alloc_tag)
    );

    operand_capture u_cap (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .accept_i   (accept),
        .tag_i      (alloc_tag),
        .a_data_i   (rd1_data),
        .a_ready_i  (rd1_ready),
        .a_tag_i    (rd1_tag),
        .b_data_i   (rd2_data),
        .b_ready_i  (rd2_ready),
        .b_tag_i    (rd2_tag),
        .wb_i       (wb_i),
        .wb_tag_i   (wb_tag_i),
        .wb_data_i  (wb_data_i),
        .issue_o    (issue_o),
        .issue_tag_o(issue_tag_o),
        .opa_data_o (opa_data_o),
        .opa_ready_o(opa_ready_o),
        .opa_tag_o  (opa_tag_o),
        .opb_data_o (opb_data_o),
        .opb_ready_o(opb_ready_o),
        .opb_tag_o  (opb_tag_o)
    );

endmodule

/* testbench/rename_properties.sv */
module rename_properties (
    input logic clk_i,
    input logic rstn_i,
    input logic disp_i,
    input logic stall_i,
    input logic wb_i,
    input logic issue_i
);

    a_issue_after_accept: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (disp_i && !stall_i) |=> issue_i
    ) else $error("no issue pulse one cycle after an accepted dispatch");

    // no pulse without an accept the cycle before
    a_issue_only_after_accept: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(disp_i && !stall_i) |=> !issue_i
    ) else $error("issue pulse without an accepted dispatch");

    // a released tag is free in the next cycle
    a_stall_only_when_empty: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        wb_i |=> !stall_i
    ) else $error("stall raised right after a tag was released");

    a_quiet_in_reset: assert property (
        @(posedge clk_i) !rstn_i |=> !issue_i
    ) else $error("issue pulse during reset");

endmodule

bind rename_stage rename_properties u_props (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .disp_i (disp_i),
    .stall_i(stall_o),
    .wb_i   (wb_i),
    .issue_i(issue_o)
);

/* testbench/tb_rename_stage.sv */
`include "rename_settings.svh"

module tb_rename_stage;
    import rename_pkg::*;

    localparam int N_TAGS     = 1 << `TAG_W;
    localparam int MAX_CYCLES = 5000;  // about twice the cycles of all tests

    logic      clk_i = 1'b0;
    logic      rstn_i;
    logic      disp_i;
    reg_addr_t disp_dst_i;
    reg_addr_t disp_src1_i;
    reg_addr_t disp_src2_i;
    logic      stall_o;
    logic      wb_i;
    reg_addr_t wb_dst_i;
    tag_t      wb_tag_i;
    data_t     wb_data_i;
    logic      issue_o;
    tag_t      issue_tag_o;
    data_t     opa_data_o;
    logic      opa_ready_o;
    tag_t      opa_tag_o;
    data_t     opb_data_o;
    logic      opb_ready_o;
    tag_t      opb_tag_o;

    // shadow model
    data_t     m_val [`N_REGS];
    logic      m_rdy [`N_REGS];
    tag_t      m_tag [`N_REGS];
    logic      m_busy [N_TAGS];
    reg_addr_t m_owner [N_TAGS];  // destination of each outstanding tag

    logic        exp_issue;
    tag_t        exp_tag;
    data_t       exp_a_data;
    data_t       exp_b_data;
    logic        exp_a_rdy;
    logic        exp_b_rdy;
    tag_t        exp_a_tag;
    tag_t        exp_b_tag;
    logic [31:0] seed = 32'd46232;
    string       cur_test;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_tests = 0;
    int          chk_base;
    int          err_base;
    int          n_cycles = 0;

    rename_stage u_dut (.*);

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        n_cycles <= n_cycles + 1;
        if (n_cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] rand_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERR %s %s: expected %0h, actual %0h", cur_test, name, exp, act);
        end
    endtask

    function automatic int lowest_free();
        for (int t = 0; t < N_TAGS; t++) begin
            if (!m_busy[t]) return t;
        end
        return -1;
    endfunction

    // first outstanding tag at or after start, wrapping
    function automatic int pick_busy(input int start);
        for (int i = 0; i < N_TAGS; i++) begin
            if (m_busy[(start + i) % N_TAGS]) return (start + i) % N_TAGS;
        end
        return -1;
    endfunction

    task automatic predict_src(input reg_addr_t s, input logic w, input tag_t wt,
                               input data_t wd, output data_t d, output logic r,
                               output tag_t t);
        d = m_val[s];
        r = m_rdy[s];
        t = m_tag[s];
        if (w && !r && wt == t) begin  // producer finishing in the accept cycle
            d = wd;
            r = 1'b1;
        end
    endtask

    task automatic run_cycle(input logic d, input reg_addr_t dst, input reg_addr_t s1,
                             input reg_addr_t s2, input logic w, input tag_t wt,
                             input data_t wd);
        int        alloc;
        logic      accept;
        reg_addr_t wdst;
        wdst = w ? m_owner[wt] : '0;
        @(posedge clk_i);
        disp_i      <= d;
        disp_dst_i  <= dst;
        disp_src1_i <= s1;
        disp_src2_i <= s2;
        wb_i        <= w;
        wb_dst_i    <= wdst;
        wb_tag_i    <= wt;
        wb_data_i   <= wd;
        @(negedge clk_i);
        alloc = lowest_free();
        check("stall", 32'(alloc < 0), 32'(stall_o));
        check("issue", 32'(exp_issue), 32'(issue_o));
        if (exp_issue && issue_o) begin
            check("issue_tag", 32'(exp_tag), 32'(issue_tag_o));
            check("opa_data", exp_a_data, opa_data_o);
            check("opa_ready", 32'(exp_a_rdy), 32'(opa_ready_o));
            check("opa_tag", 32'(exp_a_tag), 32'(opa_tag_o));
            check("opb_data", exp_b_data, opb_data_o);
            check("opb_ready", 32'(exp_b_rdy), 32'(opb_ready_o));
            check("opb_tag", 32'(exp_b_tag), 32'(opb_tag_o));
        end
        accept = d && alloc >= 0;
        if (accept) begin
            exp_tag = tag_t'(alloc);
            predict_src(s1, w, wt, wd, exp_a_data, exp_a_rdy, exp_a_tag);
            predict_src(s2, w, wt, wd, exp_b_data, exp_b_rdy, exp_b_tag);
        end
        exp_issue = accept;
        if (w) begin
            if (wdst != '0) begin
                m_val[wdst] = wd;  // value lands even when stale
                if (m_tag[wdst] == wt) m_rdy[wdst] = 1'b1;
            end
            m_busy[wt] = 1'b0;
        end
        if (accept) begin  // bind after writeback so it wins
            if (dst != '0) begin
                m_tag[dst] = tag_t'(alloc);
                m_rdy[dst] = 1'b0;
            end
            m_busy[alloc]  = 1'b1;
            m_owner[alloc] = dst;
        end
    endtask

    task automatic dispatch(input reg_addr_t dst, input reg_addr_t s1, input reg_addr_t s2);
        run_cycle(1'b1, dst, s1, s2, 1'b0, '0, '0);
    endtask

    task automatic write_back(input tag_t t, input data_t v);
        run_cycle(1'b0, '0, '0, '0, 1'b1, t, v);
    endtask

    task automatic idle();
        run_cycle(1'b0, '0, '0, '0, 1'b0, '0, '0);
    endtask

    // retire every outstanding tag, then let the last issue show
    task automatic drain();
        while (pick_busy(0) >= 0) begin
            write_back(tag_t'(pick_busy(0)), rand_next());
        end
        idle();
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        chk_base = n_checks;
        err_base = n_errors;
    endtask

    task automatic end_test();
        n_tests++;
        $display("test %-8s %0d checks, %0d errors", cur_test, n_checks - chk_base,
                 n_errors - err_base);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        tag_t        t_a;
        tag_t        t_b;
        logic        w;
        rstn_i      <= 1'b0;
        disp_i      <= 1'b0;
        disp_dst_i  <= '0;
        disp_src1_i <= '0;
        disp_src2_i <= '0;
        wb_i        <= 1'b0;
        wb_dst_i    <= '0;
        wb_tag_i    <= '0;
        wb_data_i   <= '0;
        for (int i = 0; i < `N_REGS; i++) begin
            m_val[i] = '0;
            m_rdy[i] = 1'b1;
            m_tag[i] = '0;
        end
        for (int t = 0; t < N_TAGS; t++) begin
            m_busy[t]  = 1'b0;
            m_owner[t] = '0;
        end
        exp_issue = 1'b0;
        repeat (10) @(posedge clk_i);
        rstn_i <= 1'b1;

        start_test("reset");
        dispatch(5'd3, 5'd5, 5'd0);
        dispatch(5'd4, 5'd0, 5'd7);
        idle();
        check("r0 ready", 1, 32'(opa_ready_o));
        check("r0 data", 0, opa_data_o);
        drain();
        end_test();

        start_test("rename");
        t_a = tag_t'(lowest_free());
        dispatch(5'd5, 5'd1, 5'd2);
        dispatch(5'd6, 5'd5, 5'd0);
        idle();
        check("not ready", 0, 32'(opa_ready_o));
        check("producer", 32'(t_a), 32'(opa_tag_o));
        write_back(t_a, 32'h0000_1234);
        dispatch(5'd7, 5'd5, 5'd5);
        idle();
        check("ready", 1, 32'(opb_ready_o));
        check("value", 32'h0000_1234, opb_data_o);
        drain();
        end_test();

        start_test("stale");
        t_a = tag_t'(lowest_free());
        dispatch(5'd8, 5'd0, 5'd0);
        t_b = tag_t'(lowest_free());
        dispatch(5'd8, 5'd0, 5'd0);
        write_back(t_a, 32'hbad0_0003);
        dispatch(5'd9, 5'd8, 5'd0);
        idle();
        check("ready", 0, 32'(opa_ready_o));
        check("value", 32'hbad0_0003, opa_data_o);
        check("producer", 32'(t_b), 32'(opa_tag_o));
        drain();
        end_test();

        start_test("wakeup");
        t_a = tag_t'(lowest_free());
        dispatch(5'd10, 5'd0, 5'd0);
        run_cycle(1'b1, 5'd11, 5'd10, 5'd10, 1'b1, t_a, 32'hcafe_0004);
        idle();
        check("ready", 1, 32'(opa_ready_o));
        check("value", 32'hcafe_0004, opb_data_o);
        drain();
        end_test();

        start_test("stall");
        for (int i = 0; i < 9; i++) begin
            dispatch(reg_addr_t'(12 + i), 5'd0, 5'd0);
        end
        check("pool empty", 1, 32'(stall_o));
        write_back(3'd3, 32'h0000_0005);
        check("ninth issue", 0, 32'(issue_o));
        dispatch(5'd21, 5'd0, 5'd0);
        idle();
        check("freed tag", 3, 32'(issue_tag_o));
        drain();
        end_test();

        start_test("random");
        repeat (2000) begin
            r = rand_next();
            s = rand_next();
            w = r[29:28] != 2'b00 && pick_busy(0) >= 0;
            t_a = w ? tag_t'(pick_busy(int'(r[18:16]))) : '0;
            run_cycle(r[31:30] != 2'b00, s[31:27], s[26:22], s[21:17], w, t_a, rand_next());
        end
        drain();
        end_test();

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
rtl/rename_pkg.sv
rtl/tagged_regfile.sv
rtl/tag_allocator.sv
rtl/operand_capture.sv
rtl/rename_stage.sv
testbench/rename_properties.sv
testbench/tb_rename_stage.sv

/* Makefile */
# Verilator build and run of the rename stage testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_rename_stage -f compile.f

run: compile
	./obj_dir/Vtb_rename_stage | tee sim.log
	@if grep -q "Simulation failed" sim.log; then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" sim.log; then \
		echo "run ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
